/* hdl/scsiSm_params.svh */
// SCSI sequencer parameters
// Register hold length and request register reset levels
`ifndef SCSI_SM_PARAMS_SVH
`define SCSI_SM_PARAMS_SVH

`define SCSI_REG_HOLD 2        // Cycles in REG_HOLD per register access

`define SCSI_DREQ_IDLE 1'b1    // Chip request is active low
`define SCSI_CPUREQ_IDLE 1'b0  // No CPU request after reset

`endif

/* hdl/scsiFsm_pkg.sv */
// SCSI sequencer FSM types
// State encoding of the cycle sequencer and the DMA transfer direction
package scsiFsm_pkg;

    // Sequencer states, register path first, then the DMA byte path
    typedef enum logic [2:0] {
        IDLE       = 3'd0,  // Waiting for an opcode
        REG_ASSERT = 3'd1,  // Chip select with read or write, first cycle
        REG_HOLD   = 3'd2,  // Register access held on the chip
        REG_DONE   = 3'd3,  // Terminate the CPU cycle
        DMA_ACK    = 3'd4,  // Acknowledge one byte to the chip
        DMA_STEP   = 3'd5,  // Advance the FIFO pointers
        DMA_WAIT   = 3'd6   // Wait for the chip to drop its request
    } seqState_e;

    // Direction of a DMA transfer as seen from the SCSI chip
    typedef enum logic {
        DIR_TO_FIFO = 1'b0, // SCSI to FIFO, DMA in
        DIR_TO_SCSI = 1'b1  // FIFO to SCSI, DMA out
    } dmaDir_e;

endpackage

/* hdl/scsiCycle_pkg.sv */
// SCSI cycle types
// Cycle opcode from decode and the strobe set from sequencer to result
package scsiCycle_pkg;

    typedef enum logic [1:0] {
        CYC_REG_RD  = 2'd0, // CPU reads a chip register
        CYC_REG_WR  = 2'd1, // CPU writes a chip register
        CYC_DMA_IN  = 2'd2, // One byte from chip into FIFO
        CYC_DMA_OUT = 2'd3  // One byte from FIFO to chip
    } cycleOp_e;

    // One bit per strobe, all active high
    typedef struct packed {
        logic scsiCs;    // Chip select
        logic re;        // Chip read enable
        logic we;        // Chip write enable
        logic dack;      // DMA acknowledge
        logic cpu2s;     // CPU to SCSI datapath
        logic s2cpu;     // SCSI to CPU datapath
        logic f2s;       // FIFO to SCSI datapath
        logic s2f;       // SCSI to FIFO datapath
        logic incBo;     // Step byte pointer
        logic incNi;     // Step next-in pointer
        logic incNo;     // Step next-out pointer
        logic rdFifoReq; // Ask FIFO side to fetch a longword
        logic riFifoReq; // Ask FIFO side to store a longword
        logic setTerm;   // Terminate the CPU cycle
    } strobeSet_t;

endpackage

/* hdl/scsiCtrl_if.sv */
// Control bundle between decode, sequencer and result stage
// Carries the opcode handshake, the strobe set and the FIFO-side status
interface scsiCtrl_if;
    import scsiCycle_pkg::*;

    logic       opValid;     // Decode has an opcode
    logic       opReady;     // Sequencer takes it, only in IDLE
    cycleOp_e   op;          // Stable while valid and not ready
    logic       dreqSync;    // Registered chip request, active low
    strobeSet_t strobes;     // Combinational from sequencer state
    logic       longPending; // Longword request still held

    modport dec (
        output opValid, op, dreqSync,
        input  opReady
    );

    modport seq (
        input  opValid, op, dreqSync, longPending,
        output opReady, strobes
    );

    modport res (
        input  strobes,
        output longPending
    );

endinterface

/* hdl/scsiReqDecode.sv */
// SCSI request decode
// Registers CPU and chip requests, picks one cycle opcode and holds it
`include "scsiSm_params.svh"

module scsiReqDecode (
    input  logic    CLK90,
    input  logic    AS_,
    input  logic    cpuReqValid_i,
    input  logic    cpuRw_i,        // 1 means read
    input  logic    dreqN_i,
    input  logic    dmaDir_i,
    input  logic    fifoEmpty_i,
    input  logic    fifoFull_i,
    scsiCtrl_if.dec ctrl
);
    import scsiFsm_pkg::*;
    import scsiCycle_pkg::*;

    logic     cpuValidQ;  // Registered CPU request
    logic     dreqNQ;     // Registered chip request, active low
    logic     regDone;    // Register opcode already raised for this request
    logic     dmaDone;    // DMA opcode already raised for this low period
    logic     pendQ;      // Opcode waiting for the sequencer
    cycleOp_e pendOp;
    logic     newReg;
    logic     newDma;
    logic     fifoOk;
    logic     issue;
    cycleOp_e newOp;
    dmaDir_e  dir;

    always_ff @(posedge CLK90 or posedge AS_) begin
        if (AS_) begin
            cpuValidQ <= `SCSI_CPUREQ_IDLE;
            dreqNQ    <= `SCSI_DREQ_IDLE;
        end else begin
            cpuValidQ <= cpuReqValid_i;
            dreqNQ    <= dreqN_i;
        end
    end

    assign dir    = dmaDir_e'(dmaDir_i);
    assign fifoOk = (dir == DIR_TO_FIFO) ? !fifoFull_i : !fifoEmpty_i; // Room or data needed
    assign newReg = cpuValidQ && !regDone;
    assign newDma = !dreqNQ && !dmaDone && fifoOk;
    assign issue  = !pendQ && (newReg || newDma);

    // Register access wins over DMA
    always_comb begin
        if (newReg) begin
            newOp = cpuRw_i ? CYC_REG_RD : CYC_REG_WR;
        end else if (dir == DIR_TO_SCSI) begin
            newOp = CYC_DMA_OUT;
        end else begin
            newOp = CYC_DMA_IN;
        end
    end

    assign ctrl.opValid  = pendQ || issue;
    assign ctrl.op       = pendQ ? pendOp : newOp;
    assign ctrl.dreqSync = dreqNQ;

    always_ff @(posedge CLK90 or posedge AS_) begin
        if (AS_) begin
            regDone <= 1'b0;
            dmaDone <= 1'b0;
            pendQ   <= 1'b0;
        end else begin
            if (!cpuValidQ) begin
                regDone <= 1'b0;             // Requester let go, rearm
            end else if (issue && newReg) begin
                regDone <= 1'b1;
            end
            if (dreqNQ) begin
                dmaDone <= 1'b0;             // Chip dropped its request
            end else if (issue && !newReg) begin
                dmaDone <= 1'b1;
            end
            if (pendQ) begin
                pendQ <= !ctrl.opReady;
            end else begin
                pendQ <= issue && !ctrl.opReady; // Sequencer busy, keep it
            end
        end
    end

    always_ff @(posedge CLK90) begin
        if (issue) begin
            pendOp <= newOp;
        end
    end

endmodule

/* hdl/scsiSeqFsm.sv */
// SCSI cycle sequencer
// Walks register and DMA byte cycles and drives the strobe set from its state
`include "scsiSm_params.svh"

module scsiSeqFsm (
    input  logic    CLK90,
    input  logic    AS_,
    input  logic    boEq3_i,   // Last byte of a longword
    scsiCtrl_if.seq ctrl
);
    import scsiFsm_pkg::*;
    import scsiCycle_pkg::*;

    localparam int holdW = (`SCSI_REG_HOLD > 1) ? $clog2(`SCSI_REG_HOLD) : 1;
    localparam logic [holdW-1:0] holdLast = holdW'(`SCSI_REG_HOLD - 1);

    seqState_e        state;
    cycleOp_e         curOp;    // Opcode of the running cycle
    logic [holdW-1:0] holdCnt;
    logic             dmaOp;
    logic             take;

    assign dmaOp        = (ctrl.op == CYC_DMA_IN) || (ctrl.op == CYC_DMA_OUT);
    assign ctrl.opReady = (state == IDLE) && !(dmaOp && ctrl.longPending); // Longword first
    assign take         = ctrl.opValid && ctrl.opReady;

    always_ff @(posedge CLK90 or posedge AS_) begin
        if (AS_) begin
            state   <= IDLE;
            holdCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= dmaOp ? DMA_ACK : REG_ASSERT;
                    end
                end
                REG_ASSERT: begin
                    state   <= REG_HOLD;
                    holdCnt <= '0;
                end
                REG_HOLD: begin
                    if (holdCnt == holdLast) begin
                        state <= REG_DONE;
                    end else begin
                        holdCnt <= holdCnt + 1'b1;
                    end
                end
                REG_DONE: state <= IDLE;
                DMA_ACK:  state <= DMA_STEP;
                DMA_STEP: state <= DMA_WAIT;
                DMA_WAIT: begin
                    if (ctrl.dreqSync) begin
                        state <= IDLE;       // Request released, next byte may come
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK90) begin
        if (take) begin
            curOp <= ctrl.op;
        end
    end

    always_comb begin
        ctrl.strobes = '0;
        case (state)
            REG_ASSERT, REG_HOLD: begin
                ctrl.strobes.scsiCs = 1'b1;
                if (curOp == CYC_REG_RD) begin
                    ctrl.strobes.re    = 1'b1;
                    ctrl.strobes.s2cpu = 1'b1;
                end else begin
                    ctrl.strobes.we    = 1'b1;
                    ctrl.strobes.cpu2s = 1'b1;
                end
            end
            REG_DONE: begin
                ctrl.strobes.setTerm = 1'b1;
            end
            DMA_ACK: begin
                ctrl.strobes.dack = 1'b1;
                if (curOp == CYC_DMA_IN) begin
                    ctrl.strobes.re  = 1'b1;
                    ctrl.strobes.s2f = 1'b1;
                end else begin
                    ctrl.strobes.we  = 1'b1;
                    ctrl.strobes.f2s = 1'b1;
                end
            end
            DMA_STEP: begin
                ctrl.strobes.incBo = 1'b1;
                if (boEq3_i) begin
                    // Longword complete, move it across
                    if (curOp == CYC_DMA_IN) begin
                        ctrl.strobes.incNi     = 1'b1;
                        ctrl.strobes.riFifoReq = 1'b1;
                    end else begin
                        ctrl.strobes.incNo     = 1'b1;
                        ctrl.strobes.rdFifoReq = 1'b1;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

/* hdl/scsiStrobeReg.sv */
// SCSI strobe result stage
// Registers the strobes, holds longword requests, terminates CPU cycles
module scsiStrobeReg (
    input  logic    CLK90,
    input  logic    AS_,
    input  logic    cpuReqValid_i,
    input  logic    incFifo_i,      // FIFO stored the longword
    input  logic    decFifo_i,      // FIFO fetched the longword
    scsiCtrl_if.res ctrl,
    output logic    cpuReqReady_o,
    output logic    scsiCs_o,
    output logic    re_o,
    output logic    we_o,
    output logic    dack_o,
    output logic    cpu2s_o,
    output logic    s2cpu_o,
    output logic    f2s_o,
    output logic    s2f_o,
    output logic    incBo_o,
    output logic    incNi_o,
    output logic    incNo_o,
    output logic    rdFifo_o,
    output logic    riFifo_o,
    output logic    lByteN_o
);

    always_ff @(posedge CLK90 or posedge AS_) begin
        if (AS_) begin
            scsiCs_o <= 1'b0;
            re_o     <= 1'b0;
            we_o     <= 1'b0;
            dack_o   <= 1'b0;
            cpu2s_o  <= 1'b0;
            s2cpu_o  <= 1'b0;
            f2s_o    <= 1'b0;
            s2f_o    <= 1'b0;
            incBo_o  <= 1'b0;
            incNi_o  <= 1'b0;
            incNo_o  <= 1'b0;
        end else begin
            scsiCs_o <= ctrl.strobes.scsiCs;
            re_o     <= ctrl.strobes.re;
            we_o     <= ctrl.strobes.we;
            dack_o   <= ctrl.strobes.dack;
            cpu2s_o  <= ctrl.strobes.cpu2s;
            s2cpu_o  <= ctrl.strobes.s2cpu;
            f2s_o    <= ctrl.strobes.f2s;
            s2f_o    <= ctrl.strobes.s2f;
            incBo_o  <= ctrl.strobes.incBo;
            incNi_o  <= ctrl.strobes.incNi;
            incNo_o  <= ctrl.strobes.incNo;
        end
    end

    // Longword requests, clears first and decrement before increment
    always_ff @(posedge CLK90 or posedge AS_) begin
        if (AS_) begin
            rdFifo_o <= 1'b0;
            riFifo_o <= 1'b0;
        end else if (decFifo_i) begin
            rdFifo_o <= 1'b0;
        end else if (incFifo_i) begin
            riFifo_o <= 1'b0;
        end else if (ctrl.strobes.rdFifoReq) begin
            rdFifo_o <= 1'b1;
        end else if (ctrl.strobes.riFifoReq) begin
            riFifo_o <= 1'b1;
        end
    end

    // Termination holds until the requester drops valid
    always_ff @(posedge CLK90 or posedge AS_) begin
        if (AS_) begin
            cpuReqReady_o <= 1'b0;
        end else begin
            cpuReqReady_o <= cpuReqValid_i && (cpuReqReady_o || ctrl.strobes.setTerm);
        end
    end

    assign lByteN_o         = !(dack_o && re_o);      // Load byte on a DMA-in acknowledge
    assign ctrl.longPending = rdFifo_o || riFifo_o;

endmodule

/* hdl/scsiSm.sv */
// SCSI-side sequencer of the DMA controller
// Decode, cycle sequencer and strobe registers joined by one control bundle
module scsiSm (
    input  logic CLK90,
    input  logic AS_,
    input  logic cpuReqValid_i,
    input  logic cpuRw_i,
    input  logic dreqN_i,
    input  logic dmaDir_i,
    input  logic boEq3_i,
    input  logic fifoEmpty_i,
    input  logic fifoFull_i,
    input  logic incFifo_i,
    input  logic decFifo_i,
    output logic cpuReqReady_o,
    output logic scsiCs_o,
    output logic re_o,
    output logic we_o,
    output logic dack_o,
    output logic cpu2s_o,
    output logic s2cpu_o,
    output logic f2s_o,
    output logic s2f_o,
    output logic incBo_o,
    output logic incNi_o,
    output logic incNo_o,
    output logic rdFifo_o,
    output logic riFifo_o,
    output logic lByteN_o
);

    scsiCtrl_if ctrl ();

    scsiReqDecode decode0 (
        .CLK90         (CLK90),
        .AS_           (AS_),
        .cpuReqValid_i (cpuReqValid_i),
        .cpuRw_i       (cpuRw_i),
        .dreqN_i       (dreqN_i),
        .dmaDir_i      (dmaDir_i),
        .fifoEmpty_i   (fifoEmpty_i),
        .fifoFull_i    (fifoFull_i),
        .ctrl          (ctrl.dec)
    );

    scsiSeqFsm seq0 (
        .CLK90   (CLK90),
        .AS_     (AS_),
        .boEq3_i (boEq3_i),
        .ctrl    (ctrl.seq)
    );

    scsiStrobeReg res0 (
        .CLK90         (CLK90),
        .AS_           (AS_),
        .cpuReqValid_i (cpuReqValid_i),
        .incFifo_i     (incFifo_i),
        .decFifo_i     (decFifo_i),
        .ctrl          (ctrl.res),
        .cpuReqReady_o (cpuReqReady_o),
        .scsiCs_o      (scsiCs_o),
        .re_o          (re_o),
        .we_o          (we_o),
        .dack_o        (dack_o),
        .cpu2s_o       (cpu2s_o),
        .s2cpu_o       (s2cpu_o),
        .f2s_o         (f2s_o),
        .s2f_o         (s2f_o),
        .incBo_o       (incBo_o),
        .incNi_o       (incNi_o),
        .incNo_o       (incNo_o),
        .rdFifo_o      (rdFifo_o),
        .riFifo_o      (riFifo_o),
        .lByteN_o      (lByteN_o)
    );

endmodule

/* tb/scsiSm_sva.sv */
// Bound protocol checks on the SCSI sequencer outputs
// Single-cycle acknowledge, exclusive read and write, byte pointer after acknowledge
module scsiSm_sva (
    input logic CLK90,
    input logic AS_,
    input logic dack_i,
    input logic re_i,
    input logic we_i,
    input logic incBo_i
);
    timeunit 1ns;
    timeprecision 100ps;

    assert property (@(posedge CLK90) disable iff (AS_) dack_i |=> !dack_i)
        else $error("dack_o high for two cycles in a row");

    assert property (@(posedge CLK90) disable iff (AS_) !(re_i && we_i))
        else $error("re_o and we_o high together");

    assert property (@(posedge CLK90) disable iff (AS_) dack_i |=> incBo_i)
        else $error("incBo_o missing one cycle after dack_o");

    assert property (@(posedge CLK90) disable iff (AS_) incBo_i |-> $past(dack_i))
        else $error("incBo_o without dack_o one cycle before");

endmodule

bind scsiSm scsiSm_sva sva0 (
    .CLK90   (CLK90),
    .AS_     (AS_),
    .dack_i  (dack_o),
    .re_i    (re_o),
    .we_i    (we_o),
    .incBo_i (incBo_o)
);

/* tb/scsiSm_tb.sv */
// Testbench for the SCSI-side sequencer
// Table-driven register, DMA, back-pressure and priority cycles with counted strobes
`include "scsiSm_params.svh"

module scsiSm_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import scsiFsm_pkg::*;

    logic CLK90, AS_, cpuReqValid_i, cpuRw_i, dreqN_i, dmaDir_i, boEq3_i;
    logic fifoEmpty_i, fifoFull_i, incFifo_i, decFifo_i;
    logic cpuReqReady_o, scsiCs_o, re_o, we_o, dack_o, cpu2s_o, s2cpu_o, f2s_o, s2f_o;
    logic incBo_o, incNi_o, incNo_o, rdFifo_o, riFifo_o, lByteN_o;

    int errCnt = 0;
    int tmoCnt = 0;
    int cyc = 0;
    logic [31:0] lfsr = 32'hd93f5fb8;
    bit counting = 0;
    bit rdPrev, riPrev;
    int dackCnt, incBoCnt, incNiCnt, incNoCnt, rdRise, riRise, lbLow;
    int csCnt, reCnt, weCnt, c2sCnt, s2cCnt, f2sCnt, s2fCnt, csFirst, dackFirst;

    // kind (0 reg, 1 dma, 2 priority), dir or rw, boEq3 (2 random), full, empty,
    // per byte: dack, incBo, lByteN low; per longword: incNi, incNo, rdFifo, riFifo
    int tbl [0:9][0:11] = '{
        '{0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},  // Register read
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},  // Register write
        '{1, 0, 0, 0, 0, 1, 1, 1, 0, 0, 0, 0},  // DMA in, mid longword
        '{1, 0, 1, 0, 0, 1, 1, 1, 1, 0, 0, 1},  // DMA in, last byte
        '{1, 1, 1, 0, 0, 1, 1, 0, 0, 1, 1, 0},  // DMA out, last byte
        '{1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0},  // DMA in stalled by full FIFO
        '{1, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0},  // DMA out stalled by empty FIFO
        '{1, 0, 2, 0, 0, 1, 1, 1, 1, 0, 0, 1},  // DMA in, random boEq3
        '{1, 1, 2, 0, 0, 1, 1, 0, 0, 1, 1, 0},  // DMA out, random boEq3
        '{2, 0, 0, 0, 0, 1, 1, 1, 0, 0, 0, 0}   // Register beside DMA in
    };

    scsiSm dut0 (.*);

    initial begin
        CLK90 = 1'b0;
        forever #4 CLK90 = ~CLK90;              // 8 ns period
    end

    // Strobe counters, sampled before each rising edge updates the outputs
    always @(posedge CLK90) begin
        if (counting) begin
            dackCnt  += int'(dack_o);
            incBoCnt += int'(incBo_o);
            incNiCnt += int'(incNi_o);
            incNoCnt += int'(incNo_o);
            rdRise   += int'(rdFifo_o && !rdPrev);
            riRise   += int'(riFifo_o && !riPrev);
            lbLow    += int'(!lByteN_o);
            csCnt    += int'(scsiCs_o);
            reCnt    += int'(re_o);
            weCnt    += int'(we_o);
            c2sCnt   += int'(cpu2s_o);
            s2cCnt   += int'(s2cpu_o);
            f2sCnt   += int'(f2s_o);
            s2fCnt   += int'(s2f_o);
            if (scsiCs_o && csFirst < 0) csFirst = cyc;
            if (dack_o && dackFirst < 0) dackFirst = cyc;
        end
        rdPrev = rdFifo_o;
        riPrev = riFifo_o;
        cyc++;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        lfsrNext = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois taps 32,22,2,1
    endfunction

    task automatic checkCount(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errCnt++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkIdle();
        logic [14:0] outs;
        outs = {cpuReqReady_o, scsiCs_o, re_o, we_o, dack_o, cpu2s_o, s2cpu_o, f2s_o, s2f_o,
                incBo_o, incNi_o, incNo_o, rdFifo_o, riFifo_o, lByteN_o};
        assert (outs == 15'h0001) else begin
            errCnt++;
            $display("** Error: {cpuReqReady_o..lByteN_o} in reset got %h expected %h",
                     outs, 15'h0001);
        end
    endtask

    task automatic clearCounts();
        {dackCnt, incBoCnt, incNiCnt, incNoCnt, rdRise, riRise, lbLow} = '0;
        {csCnt, reCnt, weCnt, c2sCnt, s2cCnt, f2sCnt, s2fCnt} = '0;
        csFirst   = -1;
        dackFirst = -1;
        counting  = 1;
    endtask

    task automatic waitForReady(input logic level, input int limit, output int n);
        n = 0;
        while (n < limit) begin
            @(negedge CLK90);
            n++;
            if (cpuReqReady_o == level) break;
        end
        if (cpuReqReady_o != level) begin
            tmoCnt++;
            $display("Timed out waiting for cpuReqReady_o to become %0d", level);
        end
    endtask

    task automatic waitForDack(input int limit, output bit seen);
        int n;
        n = 0;
        seen = 0;
        while (n < limit && !seen) begin
            @(negedge CLK90);
            n++;
            seen = dack_o;
        end
    endtask

    task automatic needDack(input int limit);
        bit seen;
        waitForDack(limit, seen);
        if (!seen) begin
            tmoCnt++;
            $display("Timed out waiting for dack_o");
        end
        dreqN_i = 1'b1;                           // Chip drops request after the ack
        repeat (3) @(negedge CLK90);
    endtask

    task automatic runReg(input int r);
        int n;
        bit rw, withDma;
        rw      = tbl[r][1][0];
        withDma = (tbl[r][0] == 2);
        clearCounts();
        cpuRw_i       = rw;
        cpuReqValid_i = 1'b1;
        if (withDma) begin
            dmaDir_i = DIR_TO_FIFO;               // DMA in beside the register access
            boEq3_i  = 1'b0;
            dreqN_i  = 1'b0;                      // Both requests seen on one edge
        end
        waitForReady(1'b1, 40, n);
        checkCount("cpuReqReady_o rise edge", n, 4 + `SCSI_REG_HOLD);
        cpuReqValid_i = 1'b0;
        waitForReady(1'b0, 10, n);
        if (withDma) begin
            needDack(40);
            checkCount("scsiCs_o before dack_o", int'(csFirst < dackFirst), 1);
        end
        repeat (2) @(negedge CLK90);
        checkCount("scsiCs_o", csCnt, 1 + `SCSI_REG_HOLD);
        checkCount("re_o", reCnt, int'(rw) * (1 + `SCSI_REG_HOLD) + tbl[r][7]);
        checkCount("we_o", weCnt, int'(!rw) * (1 + `SCSI_REG_HOLD));
        checkCount("cpu2s_o", c2sCnt, int'(!rw) * (1 + `SCSI_REG_HOLD));
        checkCount("s2cpu_o", s2cCnt, int'(rw) * (1 + `SCSI_REG_HOLD));
        checkCount("dack_o", dackCnt, tbl[r][5]);
        checkCount("incBo_o", incBoCnt, tbl[r][6]);
        checkCount("lByteN_o low", lbLow, tbl[r][7]);
        checkCount("s2f_o", s2fCnt, tbl[r][5]);
    endtask

    task automatic runDma(input int r);
        bit seen, b, toFifo;
        int k;
        toFifo = (tbl[r][1] == 0);
        if (tbl[r][2] == 2) begin
            lfsr = lfsrNext(lfsr);
            b    = lfsr[0];
        end else begin
            b = tbl[r][2][0];
        end
        clearCounts();
        dmaDir_i    = tbl[r][1][0];
        boEq3_i     = b;
        fifoFull_i  = tbl[r][3][0];
        fifoEmpty_i = tbl[r][4][0];
        dreqN_i     = 1'b0;
        if (tbl[r][5] == 0) begin
            waitForDack(30, seen);
            checkCount("dack_o under FIFO stall", int'(seen), 0);
            dreqN_i = 1'b1;
            repeat (3) @(negedge CLK90);          // Let the registered request go idle
            fifoFull_i  = 1'b0;
            fifoEmpty_i = 1'b0;
        end else begin
            needDack(30);
            if (b) begin
                checkCount(toFifo ? "riFifo_o held" : "rdFifo_o held",
                           int'(toFifo ? riFifo_o : rdFifo_o), 1);
                boEq3_i = 1'b0;
                dreqN_i = 1'b0;                   // Next byte must wait for the longword
                waitForDack(12, seen);
                checkCount("dack_o while longword held", int'(seen), 0);
                incFifo_i = toFifo;
                decFifo_i = !toFifo;
                @(negedge CLK90);
                incFifo_i = 1'b0;
                decFifo_i = 1'b0;
                checkCount("longword request after ack", int'(riFifo_o || rdFifo_o), 0);
                needDack(30);
            end
        end
        k = 1 + int'(b);                          // Bytes moved in this row
        checkCount("dack_o", dackCnt, tbl[r][5] * k);
        checkCount("incBo_o", incBoCnt, tbl[r][6] * k);
        checkCount("lByteN_o low", lbLow, tbl[r][7] * k);
        checkCount("re_o", reCnt, tbl[r][7] * k);
        checkCount("we_o", weCnt, int'(!toFifo) * tbl[r][5] * k);
        checkCount("f2s_o", f2sCnt, int'(!toFifo) * tbl[r][5] * k);
        checkCount("s2f_o", s2fCnt, int'(toFifo) * tbl[r][5] * k);
        checkCount("incNi_o", incNiCnt, tbl[r][8] * int'(b));
        checkCount("incNo_o", incNoCnt, tbl[r][9] * int'(b));
        checkCount("rdFifo_o rises", rdRise, tbl[r][10] * int'(b));
        checkCount("riFifo_o rises", riRise, tbl[r][11] * int'(b));
    endtask

    initial begin
        AS_ = 1'b1;
        {cpuReqValid_i, cpuRw_i, dmaDir_i, boEq3_i} = '0;
        {fifoEmpty_i, fifoFull_i, incFifo_i, decFifo_i} = '0;
        dreqN_i = 1'b1;                           // Chip request is active low
        repeat (16) begin
            @(negedge CLK90);
            checkIdle();
        end
        AS_ = 1'b0;
        @(negedge CLK90);
        checkIdle();
        for (int r = 0; r < 10; r++) begin
            if (tbl[r][0] == 1) runDma(r);
            else runReg(r);
            counting = 0;
            repeat (4) @(negedge CLK90);
        end
        $display("Checks done: %0d value errors, %0d timeouts", errCnt, tmoCnt);
        if (errCnt == 0 && tmoCnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("Watchdog expired before the test sequence finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/scsiFsm_pkg.sv
hdl/scsiCycle_pkg.sv
hdl/scsiCtrl_if.sv
hdl/scsiReqDecode.sv
hdl/scsiSeqFsm.sv
hdl/scsiStrobeReg.sv
hdl/scsiSm.sv
tb/scsiSm_sva.sv
tb/scsiSm_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the SCSI sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module scsiSm_tb -f files.f -Mdir obj_dir -o simv
./obj_dir/simv > sim.log 2>&1
cat sim.log
if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
